//--- npu.f
design/npu_pkg.sv
design/buffer_bank.sv
design/buffer_router.sv
design/npu_regs.sv
design/stream_in.sv
design/stream_out.sv
design/qadd_engine.sv
design/npu_top.sv
verif/npu_tb.sv

//--- verif/npu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module npu_tb;

    logic                           clk;
    logic                           rst;
    logic                           reg_we;
    npu_pkg::reg_addr_e             reg_addr;
    logic [npu_pkg::REG_WIDTH-1:0]  reg_wdata;
    logic [npu_pkg::REG_WIDTH-1:0]  reg_rdata;
    logic [npu_pkg::WORD_WIDTH-1:0] s_axis_tdata;
    logic                           s_axis_tlast;
    logic                           s_axis_tvalid;
    logic                           s_axis_tready;
    logic [npu_pkg::WORD_WIDTH-1:0] m_axis_tdata;
    logic                           m_axis_tlast;
    logic                           m_axis_tvalid;
    logic                           m_axis_tready;
    logic                           irq;

    logic [31:0] rng = 32'd27010;
    int          cycles = 0;
    logic [63:0] tx [256];                           // Words to send
    logic [63:0] got [256];                          // Words received
    logic [63:0] db0_ref [256];                      // Expected bank contents
    logic [63:0] db1_ref [256];

    npu_top dut_i (
        .clk, .rst, .reg_we, .reg_addr, .reg_wdata, .reg_rdata,
        .s_axis_tdata, .s_axis_tlast, .s_axis_tvalid, .s_axis_tready,
        .m_axis_tdata, .m_axis_tlast, .m_axis_tvalid, .m_axis_tready,
        .irq
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Limit covers about 150 moved words at three cycles each plus register traffic
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 20000) begin
            $display("Timeout: the run did not finish within 20000 cycles");
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] value, input logic [63:0] exp);
        if (value !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, value, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic model_write(input npu_pkg::buf_id_e id, input logic [7:0] addr,
                               input logic [63:0] data);
        if (id == npu_pkg::BUF_DB1)
            db1_ref[addr] = data;
        else
            db0_ref[addr] = data;
    endtask

    function automatic logic [63:0] model_read(input npu_pkg::buf_id_e id, input logic [7:0] addr);
        return (id == npu_pkg::BUF_DB1) ? db1_ref[addr] : db0_ref[addr];
    endfunction

    // Lane rule with scaled differences, floor shift, bias and clip to 0..255
    function automatic logic [7:0] qadd_lane(input logic [7:0] a, input logic [7:0] b,
                                             input logic [7:0] za, input logic [7:0] zb,
                                             input logic [7:0] zc, input logic [15:0] sa,
                                             input logic [15:0] sb);
        int sum;
        int v;
        sum = (int'(a) - int'(za)) * int'(sa) + (int'(b) - int'(zb)) * int'(sb);
        v   = (sum >>> npu_pkg::SCALE_FRAC) + int'(zc);
        if (v < 0)
            return 8'd0;
        else if (v > 255)
            return 8'd255;
        return v[7:0];
    endfunction

    function automatic logic [63:0] qadd_word(input logic [63:0] a, input logic [63:0] b,
                                              input logic [31:0] zp, input logic [31:0] sc);
        logic [63:0] w;
        for (int l = 0; l < npu_pkg::LANES; l++)
            w[l*8 +: 8] = qadd_lane(a[l*8 +: 8], b[l*8 +: 8], zp[7:0], zp[15:8], zp[23:16],
                                    sc[15:0], sc[31:16]);
        return w;
    endfunction

    task automatic reg_write(input npu_pkg::reg_addr_e addr, input logic [31:0] data);
        @(posedge clk);
        reg_we    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_we    <= 1'b0;
    endtask

    task automatic reg_read(input npu_pkg::reg_addr_e addr, output logic [31:0] data);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        data = reg_rdata;
    endtask

    // Poll STATUS until the done bit is up and check that busy has cleared
    task automatic wait_done(input int bit_idx);
        logic [31:0] s;
        s = '0;
        while (!s[bit_idx])
            reg_read(npu_pkg::REG_STATUS, s);
        check_eq("STATUS", s, 64'(1) << bit_idx);
    endtask

    task automatic clear_done(input int bit_idx);
        logic [31:0] s;
        check_eq("irq", irq, 1'b1);
        reg_write(npu_pkg::REG_STATUS, 32'(1) << bit_idx);
        reg_read(npu_pkg::REG_STATUS, s);
        check_eq("STATUS", s, 0);
        check_eq("irq", irq, 1'b0);
    endtask

    task automatic stream_write(input npu_pkg::buf_id_e id, input logic [7:0] base, input int n);
        int   k;
        logic taken;
        reg_write(npu_pkg::REG_DMA_WR, {15'd0, id, 8'd0, base});
        reg_write(npu_pkg::REG_CTRL, {30'd0, npu_pkg::CMD_STREAM_IN});
        k = 0;
        s_axis_tvalid <= 1'b1;
        s_axis_tdata  <= tx[0];
        s_axis_tlast  <= (n == 1);
        while (k < n) begin
            @(negedge clk);
            taken = s_axis_tready;                   // tvalid is held high here
            @(posedge clk);
            if (taken) begin
                model_write(id, base + 8'(k), tx[k]);
                k++;
                if (k < n) begin
                    s_axis_tdata <= tx[k];
                    s_axis_tlast <= (k == n - 1);
                end else begin
                    s_axis_tvalid <= 1'b0;
                    s_axis_tlast  <= 1'b0;
                end
            end
        end
        wait_done(0);
        clear_done(0);
    endtask

    // Random tready stalls with a beat taken where tvalid and tready meet
    task automatic stream_read(input npu_pkg::buf_id_e id, input logic [7:0] base, input int n);
        int k;
        reg_write(npu_pkg::REG_DMA_RD, {15'd0, id, 8'(n - 1), base});
        reg_write(npu_pkg::REG_CTRL, {30'd0, npu_pkg::CMD_STREAM_OUT});
        k = 0;
        while (k < n) begin
            @(posedge clk);
            m_axis_tready <= (xorshift32() & 32'h3) != 0;
            @(negedge clk);
            if (m_axis_tvalid && m_axis_tready) begin
                got[k] = m_axis_tdata;
                check_eq("m_axis_tlast", m_axis_tlast, k == n - 1);
                k++;
            end
        end
        @(posedge clk);
        m_axis_tready <= 1'b0;
        wait_done(1);
        clear_done(1);
    endtask

    task automatic compare_buffer(input npu_pkg::buf_id_e id, input logic [7:0] base, input int n);
        stream_read(id, base, n);
        for (int i = 0; i < n; i++)
            check_eq("m_axis_tdata", got[i], model_read(id, base + 8'(i)));
    endtask

    task automatic qadd_run(input logic [7:0] a_addr, input logic [7:0] b_addr,
                            input logic [7:0] out_addr, input int n,
                            input logic [31:0] zp, input logic [31:0] sc);
        reg_write(npu_pkg::REG_QADD_ADDR, {8'(n - 1), out_addr, b_addr, a_addr});
        reg_write(npu_pkg::REG_QADD_BUF, 32'b10);    // Read DB0, write DB1
        reg_write(npu_pkg::REG_QADD_ZP, zp);
        reg_write(npu_pkg::REG_QADD_SCALE, sc);
        reg_write(npu_pkg::REG_CTRL, {30'd0, npu_pkg::CMD_QADD});
        wait_done(2);
        clear_done(2);
        for (int i = 0; i < n; i++)
            model_write(npu_pkg::BUF_DB1, out_addr + 8'(i),
                        qadd_word(db0_ref[a_addr + 8'(i)], db0_ref[b_addr + 8'(i)], zp, sc));
    endtask

    task automatic test_reset_state();
        logic [31:0] s;
        reg_read(npu_pkg::REG_STATUS, s);
        check_eq("STATUS", s, 0);
        check_eq("irq", irq, 1'b0);
        check_eq("s_axis_tready", s_axis_tready, 1'b0);
        check_eq("m_axis_tvalid", m_axis_tvalid, 1'b0);
    endtask

    task automatic test_stream_loop();
        for (int i = 0; i < 16; i++)
            tx[i] = {xorshift32(), xorshift32()};
        stream_write(npu_pkg::BUF_DB0, 8'd10, 16);
        compare_buffer(npu_pkg::BUF_DB0, 8'd10, 16);
    endtask

    task automatic test_bank_select();
        for (int i = 0; i < 16; i++)
            tx[i] = {xorshift32(), xorshift32()};
        stream_write(npu_pkg::BUF_DB1, 8'd10, 16);
        compare_buffer(npu_pkg::BUF_DB0, 8'd10, 16);
        compare_buffer(npu_pkg::BUF_DB1, 8'd10, 16);
    endtask

    task automatic test_qadd_random();
        logic [31:0] zp;
        logic [31:0] sc;
        for (int i = 0; i < 24; i++)
            tx[i] = {xorshift32(), xorshift32()};
        stream_write(npu_pkg::BUF_DB0, 8'd40, 24);   // a at 40, b at 52
        zp = xorshift32() & 32'h00FF_FFFF;
        sc = xorshift32() & 32'h01FF_01FF;           // Scales below 2.0 keep most lanes in range
        qadd_run(8'd40, 8'd52, 8'd100, 12, zp, sc);
        compare_buffer(npu_pkg::BUF_DB1, 8'd100, 12);
    endtask

    // Scale 4.0 on both sides drives every lane to a rail
    task automatic test_qadd_saturate();
        tx[0] = 64'hFF00_FF00_FF00_FF00;
        tx[1] = 64'hFF00_FF00_FF00_FF00;
        stream_write(npu_pkg::BUF_DB0, 8'd70, 2);
        qadd_run(8'd70, 8'd71, 8'd200, 1, 32'h0080_8080, 32'h0400_0400);
        compare_buffer(npu_pkg::BUF_DB1, 8'd200, 1);
        check_eq("m_axis_tdata", got[0], 64'hFF00_FF00_FF00_FF00);   // Rails worked out by hand
    endtask

    initial begin
        rst           <= 1'b1;
        reg_we        <= 1'b0;
        reg_addr      <= npu_pkg::REG_CTRL;
        reg_wdata     <= '0;
        s_axis_tdata  <= '0;
        s_axis_tlast  <= 1'b0;
        s_axis_tvalid <= 1'b0;
        m_axis_tready <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_stream_loop();
        test_bank_select();
        test_qadd_random();
        test_qadd_saturate();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/npu_top.sv
`timescale 1ns/1ps
`default_nettype none

module npu_top (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           reg_we,
    input  wire npu_pkg::reg_addr_e             reg_addr,
    input  wire logic [npu_pkg::REG_WIDTH-1:0]  reg_wdata,
    output logic      [npu_pkg::REG_WIDTH-1:0]  reg_rdata,
    input  wire logic [npu_pkg::WORD_WIDTH-1:0] s_axis_tdata,
    input  wire logic                           s_axis_tlast,
    input  wire logic                           s_axis_tvalid,
    output logic                                s_axis_tready,
    output logic      [npu_pkg::WORD_WIDTH-1:0] m_axis_tdata,
    output logic                                m_axis_tlast,
    output logic                                m_axis_tvalid,
    input  wire logic                           m_axis_tready,
    output logic                                irq
);

    logic                           in_start, out_start, qadd_start;
    logic                           in_done, out_done, qadd_done;
    npu_pkg::dma_wr_cfg_t           wr_cfg;
    npu_pkg::dma_rd_cfg_t           rd_cfg;
    npu_pkg::qadd_cfg_t             q_cfg;
    npu_pkg::buf_wr_t               in_wr, q_wr;
    npu_pkg::buf_rd_t               out_rd, q_rd;
    logic [npu_pkg::WORD_WIDTH-1:0] rd_data;      // Shared by both readers

    npu_regs regs_i (
        .clk, .rst, .reg_we, .reg_addr, .reg_wdata, .reg_rdata,
        .in_start, .out_start, .qadd_start,
        .in_done, .out_done, .qadd_done,
        .wr_cfg, .rd_cfg, .q_cfg, .irq
    );

    stream_in stream_in_i (
        .clk, .rst, .start(in_start), .wr_cfg,
        .s_axis_tdata, .s_axis_tlast, .s_axis_tvalid, .s_axis_tready,
        .wr(in_wr), .done(in_done)
    );

    stream_out stream_out_i (
        .clk, .rst, .start(out_start), .rd_cfg, .rd_data, .rd(out_rd),
        .m_axis_tdata, .m_axis_tlast, .m_axis_tvalid, .m_axis_tready,
        .done(out_done)
    );

    qadd_engine qadd_i (
        .clk, .rst, .start(qadd_start), .q_cfg, .rd_data,
        .rd(q_rd), .wr(q_wr), .done(qadd_done)
    );

    buffer_router router_i (
        .clk, .rst, .in_wr, .q_wr, .out_rd, .q_rd, .rd_data
    );

endmodule

`default_nettype wire

//--- design/qadd_engine.sv
`timescale 1ns/1ps
`default_nettype none

module qadd_engine (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           start,
    input  wire npu_pkg::qadd_cfg_t             q_cfg,
    input  wire logic [npu_pkg::WORD_WIDTH-1:0] rd_data,
    output npu_pkg::buf_rd_t                    rd,
    output npu_pkg::buf_wr_t                    wr,
    output logic                                done
);

    localparam int LW  = npu_pkg::LANE_WIDTH;
    localparam int ACC = 3 * LW + 2;                 // MSB of the scaled sum
    localparam int SHF = ACC - npu_pkg::SCALE_FRAC;

    typedef enum logic [1:0] {IDLE, READ_A, READ_B, DRAIN} state_e;

    state_e                         state;
    logic [npu_pkg::ADDR_WIDTH-1:0] idx;
    logic [npu_pkg::ADDR_WIDTH-1:0] wr_idx;
    logic                           a_vld;
    logic                           b_vld;
    logic                           s1_vld;
    logic [npu_pkg::WORD_WIDTH-1:0] a_q;
    logic [npu_pkg::WORD_WIDTH-1:0] sat;
    logic signed [LW:0]             diff_a [npu_pkg::LANES];
    logic signed [LW:0]             diff_b [npu_pkg::LANES];
    logic signed [ACC:0]            acc    [npu_pkg::LANES];
    logic signed [SHF:0]            shf_q  [npu_pkg::LANES];
    logic signed [SHF+1:0]          biased [npu_pkg::LANES];

    assign rd.en   = (state == READ_A) || (state == READ_B);
    assign rd.id   = q_cfg.rd_id;
    assign rd.addr = ((state == READ_B) ? q_cfg.b_addr : q_cfg.a_addr) + idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    idx   <= '0;
                    state <= READ_A;
                end
                READ_A: state <= READ_B;
                READ_B: if (idx == q_cfg.count) begin
                    state <= DRAIN;
                end else begin
                    idx   <= idx + 1'b1;
                    state <= READ_A;
                end
                DRAIN: if (wr.en && !s1_vld && !b_vld) begin   // Last write leaving
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        for (int l = 0; l < npu_pkg::LANES; l++) begin
            diff_a[l] = $signed({1'b0, a_q[l*LW +: LW]}) - $signed({1'b0, q_cfg.zp_a});
            diff_b[l] = $signed({1'b0, rd_data[l*LW +: LW]}) - $signed({1'b0, q_cfg.zp_b});
            acc[l]    = diff_a[l] * $signed({1'b0, q_cfg.scale_a})
                        + diff_b[l] * $signed({1'b0, q_cfg.scale_b});
            biased[l] = shf_q[l] + $signed({1'b0, q_cfg.zp_c});
            if (biased[l] < 0)
                sat[l*LW +: LW] = '0;
            else if (biased[l][SHF+1:LW] != '0)
                sat[l*LW +: LW] = '1;                  // Clip at 255
            else
                sat[l*LW +: LW] = biased[l][LW-1:0];
        end
    end

    // Three stages latch a, form the scaled sum with b and register the output
    always_ff @(posedge clk) begin
        if (a_vld)
            a_q <= rd_data;
        if (b_vld) begin
            for (int l = 0; l < npu_pkg::LANES; l++)
                shf_q[l] <= acc[l][ACC:npu_pkg::SCALE_FRAC];   // Floor shift
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a_vld  <= 1'b0;
            b_vld  <= 1'b0;
            s1_vld <= 1'b0;
            wr_idx <= '0;
            wr.en  <= 1'b0;
        end else begin
            a_vld   <= (state == READ_A);
            b_vld   <= (state == READ_B);
            s1_vld  <= b_vld;
            wr.en   <= s1_vld;
            wr.id   <= q_cfg.wr_id;
            wr.addr <= q_cfg.out_addr + wr_idx;
            wr.data <= sat;
            if (start)
                wr_idx <= '0;
            else if (s1_vld)
                wr_idx <= wr_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/stream_out.sv
`timescale 1ns/1ps
`default_nettype none

module stream_out (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           start,
    input  wire npu_pkg::dma_rd_cfg_t           rd_cfg,
    input  wire logic [npu_pkg::WORD_WIDTH-1:0] rd_data,
    output npu_pkg::buf_rd_t                    rd,
    output logic      [npu_pkg::WORD_WIDTH-1:0] m_axis_tdata,
    output logic                                m_axis_tlast,
    output logic                                m_axis_tvalid,
    input  wire logic                           m_axis_tready,
    output logic                                done
);

    logic                           issuing;
    logic                           pend;            // Read data returns this cycle
    logic [npu_pkg::ADDR_WIDTH-1:0] iss_cnt;
    logic [npu_pkg::ADDR_WIDTH-1:0] acc_cnt;
    logic [npu_pkg::WORD_WIDTH-1:0] q_mem [2];
    logic                           q_wp;
    logic                           q_rp;
    logic [1:0]                     q_cnt;
    logic                           space;
    logic                           accept;
    logic                           push;
    logic                           pop;

    // Count the read in flight as taken, so the queue can never overflow
    assign space = (q_cnt == 2'd0) || (q_cnt == 2'd1 && !pend);

    assign rd.en   = issuing && space;
    assign rd.id   = rd_cfg.id;
    assign rd.addr = rd_cfg.base + iss_cnt;

    // Empty queue passes returning data straight through
    assign m_axis_tvalid = (q_cnt != 2'd0) || pend;
    assign m_axis_tdata  = (q_cnt != 2'd0) ? q_mem[q_rp] : rd_data;
    assign m_axis_tlast  = m_axis_tvalid && (acc_cnt == rd_cfg.count);

    assign accept = m_axis_tvalid && m_axis_tready;
    assign push   = pend && !(q_cnt == 2'd0 && accept);
    assign pop    = accept && (q_cnt != 2'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            issuing <= 1'b0;
            pend    <= 1'b0;
            iss_cnt <= '0;
            acc_cnt <= '0;
            q_wp    <= 1'b0;
            q_rp    <= 1'b0;
            q_cnt   <= '0;
            done    <= 1'b0;
        end else begin
            pend <= rd.en;
            done <= accept && m_axis_tlast;
            if (start) begin
                issuing <= 1'b1;
                iss_cnt <= '0;
                acc_cnt <= '0;
            end else begin
                if (rd.en) begin
                    iss_cnt <= iss_cnt + 1'b1;
                    if (iss_cnt == rd_cfg.count)
                        issuing <= 1'b0;
                end
                if (accept)
                    acc_cnt <= acc_cnt + 1'b1;
            end
            if (push)
                q_wp <= ~q_wp;
            if (pop)
                q_rp <= ~q_rp;
            q_cnt <= q_cnt + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            q_mem[q_wp] <= rd_data;
    end

endmodule

`default_nettype wire

//--- design/stream_in.sv
`timescale 1ns/1ps
`default_nettype none

module stream_in (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           start,
    input  wire npu_pkg::dma_wr_cfg_t           wr_cfg,
    input  wire logic [npu_pkg::WORD_WIDTH-1:0] s_axis_tdata,
    input  wire logic                           s_axis_tlast,
    input  wire logic                           s_axis_tvalid,
    output logic                                s_axis_tready,
    output npu_pkg::buf_wr_t                    wr,
    output logic                                done
);

    logic [npu_pkg::ADDR_WIDTH-1:0] idx;            // Beat index
    logic                           accept;

    assign accept = s_axis_tvalid && s_axis_tready;

    // Accepted beat goes straight to the bank
    assign wr.en   = accept;
    assign wr.id   = wr_cfg.id;
    assign wr.addr = wr_cfg.base + idx;
    assign wr.data = s_axis_tdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_axis_tready <= 1'b0;
            idx           <= '0;
            done          <= 1'b0;
        end else begin
            done <= accept && s_axis_tlast;
            if (start) begin
                s_axis_tready <= 1'b1;
                idx           <= '0;
            end else if (accept) begin
                idx <= idx + 1'b1;
                if (s_axis_tlast)
                    s_axis_tready <= 1'b0;   // Stop after the last beat
            end
        end
    end

endmodule

`default_nettype wire

//--- design/npu_regs.sv
`timescale 1ns/1ps
`default_nettype none

module npu_regs (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           reg_we,
    input  wire npu_pkg::reg_addr_e             reg_addr,
    input  wire logic [npu_pkg::REG_WIDTH-1:0]  reg_wdata,
    output logic      [npu_pkg::REG_WIDTH-1:0]  reg_rdata,
    output logic                                in_start,
    output logic                                out_start,
    output logic                                qadd_start,
    input  wire logic                           in_done,
    input  wire logic                           out_done,
    input  wire logic                           qadd_done,
    output npu_pkg::dma_wr_cfg_t                wr_cfg,
    output npu_pkg::dma_rd_cfg_t                rd_cfg,
    output npu_pkg::qadd_cfg_t                  q_cfg,
    output logic                                irq
);

    npu_pkg::cmd_e cmd;
    npu_pkg::cmd_e cmd_q;
    logic          ctrl_we;
    logic [2:0]    clr_mask;                         // Write-1-to-clear of done bits
    logic [2:0]    done_q;                           // qadd, out, in
    logic [2:0]    busy_q;

    assign cmd      = npu_pkg::cmd_e'(reg_wdata[1:0]);
    assign ctrl_we  = reg_we && (reg_addr == npu_pkg::REG_CTRL);
    assign clr_mask = (reg_we && reg_addr == npu_pkg::REG_STATUS) ? reg_wdata[2:0] : 3'b000;
    assign irq      = |done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_start   <= 1'b0;
            out_start  <= 1'b0;
            qadd_start <= 1'b0;
            cmd_q      <= npu_pkg::CMD_NONE;
            done_q     <= '0;
            busy_q     <= '0;
            wr_cfg     <= '0;
            rd_cfg     <= '0;
            q_cfg      <= '0;
        end else begin
            in_start   <= ctrl_we && (cmd == npu_pkg::CMD_STREAM_IN);
            out_start  <= ctrl_we && (cmd == npu_pkg::CMD_STREAM_OUT);
            qadd_start <= ctrl_we && (cmd == npu_pkg::CMD_QADD);
            // A new done event wins over a clear in the same cycle
            done_q <= (done_q & ~clr_mask) | {qadd_done, out_done, in_done};
            busy_q <= (busy_q | {qadd_start, out_start, in_start})
                      & ~{qadd_done, out_done, in_done};
            if (reg_we) begin
                case (reg_addr)
                    npu_pkg::REG_CTRL: cmd_q <= cmd;
                    npu_pkg::REG_DMA_WR: begin
                        wr_cfg.id   <= npu_pkg::buf_id_e'(reg_wdata[16]);
                        wr_cfg.base <= reg_wdata[7:0];
                    end
                    npu_pkg::REG_DMA_RD: begin
                        rd_cfg.id    <= npu_pkg::buf_id_e'(reg_wdata[16]);
                        rd_cfg.count <= reg_wdata[15:8];
                        rd_cfg.base  <= reg_wdata[7:0];
                    end
                    npu_pkg::REG_QADD_ADDR: begin
                        q_cfg.a_addr   <= reg_wdata[7:0];
                        q_cfg.b_addr   <= reg_wdata[15:8];
                        q_cfg.out_addr <= reg_wdata[23:16];
                        q_cfg.count    <= reg_wdata[31:24];
                    end
                    npu_pkg::REG_QADD_BUF: begin
                        q_cfg.rd_id <= npu_pkg::buf_id_e'(reg_wdata[0]);
                        q_cfg.wr_id <= npu_pkg::buf_id_e'(reg_wdata[1]);
                    end
                    npu_pkg::REG_QADD_ZP: begin
                        q_cfg.zp_a <= reg_wdata[7:0];
                        q_cfg.zp_b <= reg_wdata[15:8];
                        q_cfg.zp_c <= reg_wdata[23:16];
                    end
                    npu_pkg::REG_QADD_SCALE: begin
                        q_cfg.scale_a <= reg_wdata[15:0];
                        q_cfg.scale_b <= reg_wdata[31:16];
                    end
                    default: ;                        // STATUS handled above
                endcase
            end
        end
    end

    // Read mux follows reg_addr without a register stage
    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            npu_pkg::REG_CTRL: reg_rdata[1:0] = cmd_q;
            npu_pkg::REG_STATUS: begin
                reg_rdata[6:4] = busy_q;
                reg_rdata[2:0] = done_q;
            end
            npu_pkg::REG_DMA_WR: begin
                reg_rdata[16]  = wr_cfg.id;
                reg_rdata[7:0] = wr_cfg.base;
            end
            npu_pkg::REG_DMA_RD: begin
                reg_rdata[16]   = rd_cfg.id;
                reg_rdata[15:8] = rd_cfg.count;
                reg_rdata[7:0]  = rd_cfg.base;
            end
            npu_pkg::REG_QADD_ADDR:
                reg_rdata = {q_cfg.count, q_cfg.out_addr, q_cfg.b_addr, q_cfg.a_addr};
            npu_pkg::REG_QADD_BUF: begin
                reg_rdata[1] = q_cfg.wr_id;
                reg_rdata[0] = q_cfg.rd_id;
            end
            npu_pkg::REG_QADD_ZP: reg_rdata[23:0] = {q_cfg.zp_c, q_cfg.zp_b, q_cfg.zp_a};
            npu_pkg::REG_QADD_SCALE: reg_rdata = {q_cfg.scale_b, q_cfg.scale_a};
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- design/buffer_router.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_router (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire npu_pkg::buf_wr_t               in_wr,
    input  wire npu_pkg::buf_wr_t               q_wr,
    input  wire npu_pkg::buf_rd_t               out_rd,
    input  wire npu_pkg::buf_rd_t               q_rd,
    output logic      [npu_pkg::WORD_WIDTH-1:0] rd_data
);

    npu_pkg::buf_wr_t               wr;
    npu_pkg::buf_rd_t               rd;
    npu_pkg::buf_id_e               rd_id_q;         // Bank of the read in flight
    logic [npu_pkg::WORD_WIDTH-1:0] db0_rdata;
    logic [npu_pkg::WORD_WIDTH-1:0] db1_rdata;

    // qadd has priority
    assign wr = q_wr.en ? q_wr : in_wr;
    assign rd = q_rd.en ? q_rd : out_rd;

    always_ff @(posedge clk) begin
        if (rst)
            rd_id_q <= npu_pkg::BUF_DB0;
        else if (rd.en)
            rd_id_q <= rd.id;
    end

    assign rd_data = (rd_id_q == npu_pkg::BUF_DB1) ? db1_rdata : db0_rdata;

    buffer_bank db0_i (
        .clk   (clk),
        .we    (wr.en && wr.id == npu_pkg::BUF_DB0),
        .waddr (wr.addr),
        .wdata (wr.data),
        .re    (rd.en && rd.id == npu_pkg::BUF_DB0),
        .raddr (rd.addr),
        .rdata (db0_rdata)
    );

    buffer_bank db1_i (
        .clk   (clk),
        .we    (wr.en && wr.id == npu_pkg::BUF_DB1),
        .waddr (wr.addr),
        .wdata (wr.data),
        .re    (rd.en && rd.id == npu_pkg::BUF_DB1),
        .raddr (rd.addr),
        .rdata (db1_rdata)
    );

endmodule

`default_nettype wire

//--- design/buffer_bank.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_bank (
    input  wire logic                           clk,
    input  wire logic                           we,
    input  wire logic [npu_pkg::ADDR_WIDTH-1:0] waddr,
    input  wire logic [npu_pkg::WORD_WIDTH-1:0] wdata,
    input  wire logic                           re,
    input  wire logic [npu_pkg::ADDR_WIDTH-1:0] raddr,
    output logic      [npu_pkg::WORD_WIDTH-1:0] rdata
);

    logic [npu_pkg::WORD_WIDTH-1:0] mem [2**npu_pkg::ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
        if (re)
            rdata <= mem[raddr];   // Holds last word when idle
    end

endmodule

`default_nettype wire

//--- design/npu_pkg.sv
`default_nettype none

package npu_pkg;

    localparam int LANE_WIDTH = 8;
    localparam int LANES      = 8;
    localparam int WORD_WIDTH = LANE_WIDTH * LANES;
    localparam int ADDR_WIDTH = 8;                   // 256 words per bank
    localparam int REG_WIDTH  = 32;
    localparam int SCALE_FRAC = 8;                   // Fraction bits of a scale

    typedef enum logic {BUF_DB0, BUF_DB1} buf_id_e;

    typedef enum logic [1:0] {
        CMD_NONE, CMD_STREAM_IN, CMD_STREAM_OUT, CMD_QADD
    } cmd_e;

    // Register word addresses
    typedef enum logic [3:0] {
        REG_CTRL       = 4'd0,
        REG_STATUS     = 4'd1,
        REG_DMA_WR     = 4'd2,
        REG_DMA_RD     = 4'd3,
        REG_QADD_ADDR  = 4'd4,
        REG_QADD_BUF   = 4'd5,
        REG_QADD_ZP    = 4'd6,
        REG_QADD_SCALE = 4'd7
    } reg_addr_e;

    typedef struct packed {
        buf_id_e               id;
        logic [ADDR_WIDTH-1:0] base;
    } dma_wr_cfg_t;

    typedef struct packed {
        buf_id_e               id;
        logic [ADDR_WIDTH-1:0] base;
        logic [ADDR_WIDTH-1:0] count;                // Words minus one
    } dma_rd_cfg_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  a_addr;
        logic [ADDR_WIDTH-1:0]  b_addr;
        logic [ADDR_WIDTH-1:0]  out_addr;
        logic [ADDR_WIDTH-1:0]  count;
        buf_id_e                rd_id;
        buf_id_e                wr_id;
        logic [LANE_WIDTH-1:0]  zp_a;
        logic [LANE_WIDTH-1:0]  zp_b;
        logic [LANE_WIDTH-1:0]  zp_c;
        logic [REG_WIDTH/2-1:0] scale_a;
        logic [REG_WIDTH/2-1:0] scale_b;
    } qadd_cfg_t;

    typedef struct packed {
        logic                  en;
        buf_id_e               id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] data;
    } buf_wr_t;

    typedef struct packed {
        logic                  en;
        buf_id_e               id;
        logic [ADDR_WIDTH-1:0] addr;
    } buf_rd_t;

endpackage

`default_nettype wire
